/* fetch_sub.f */
+incdir+include
hdl/fetch_pkg.sv
hdl/axi_rd_if.sv
hdl/cache_refill_if.sv
hdl/pc_predict.sv
hdl/i_cache.sv
hdl/axi_rd_master.sv
hdl/inst_mem_slave.sv
hdl/if_stage.sv
verification/if_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module if_stage_tb -f fetch_sub.f -o if_stage_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_output=$(./obj_dir/if_stage_sim 2>&1)
status=$?
echo "$sim_output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$sim_output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verification/if_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module if_stage_tb;

  localparam int CLK_PERIOD = 10;
  localparam int N_STRAIGHT = 200;     // from reset without stall or redirect
  localparam int N_RANDOM   = 1500;    // random stalls and redirects
  localparam int N_RELOAD   = 48;      // after reload and flush
  localparam int N_TOTAL    = N_STRAIGHT + N_RANDOM + N_RELOAD;
  // a running refill plus our own
  localparam int WORST_MISS = 2 * (`MEM_DELAY + `LINE_WORDS + 4);
  localparam int TIMEOUT_CYC = `MEM_WORDS + 200 + N_TOTAL * WORST_MISS;

  logic             clk;
  logic             rst_n;
  logic             stall_i;
  logic             redirect_i;
  logic [`XLEN-1:0] redirect_pc_i;
  logic             flush_i;
  logic             load_en_i;
  logic [`XLEN-1:0] load_addr_i;
  logic [`ILEN-1:0] load_data_i;
  logic             inst_valid_o;
  logic [`ILEN-1:0] inst_o;
  logic [`XLEN-1:0] inst_pc_o;

  // reference model state
  logic [`ILEN-1:0] image [`MEM_WORDS];  // program as the memory should hold it
  logic [`XLEN-1:0] exp_pc;
  logic [`XLEN-1:0] last_pc;             // pc of the last presented instruction
  logic             block_q;             // stall or redirect seen last cycle
  int unsigned      n_checked;
  int unsigned      n_jal;
  int unsigned      n_redirect;

  if_stage if_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .flush_i       (flush_i),
    .load_en_i     (load_en_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string sig, input logic [31:0] expv,
                               input logic [31:0] gotv);
    $display("MISMATCH at %t: %s expected %08h got %08h", $time, sig, expv, gotv);
    abort_run();
  endtask

  task automatic stop_on_error(input string msg);
    $display("ERROR at %t: %s", $time, msg);
    abort_run();
  endtask

  // 1 in 8 words is a jal with a short nonzero word offset
  function automatic logic [`ILEN-1:0] make_word();
    logic [31:0] r;
    logic [20:0] off;
    r = $urandom;
    if (r[2:0] == 3'd0) begin
      off = {13'd0, {1'b0, r[8:4]} + 6'd1, 2'b00}; // 1 to 32 words
      if (r[9]) off = -off;            // backward jump
      return {off[20], off[10:1], off[11], off[19:12], r[14:10], `OPC_JAL};
    end
    r = $urandom;
    if (r[6:0] == `OPC_JAL) r[6:0] = 7'h13; // keep it a plain word
    return r;
  endfunction

  // successor pc with every jal taken
  function automatic logic [`XLEN-1:0] next_pc(input logic [`XLEN-1:0] pc,
                                               input logic [`ILEN-1:0] inst);
    logic [`XLEN-1:0] imm;
    if (inst[6:0] == `OPC_JAL) begin
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  // word aligned target inside the 4 KiB image
  function automatic logic [`XLEN-1:0] rand_target();
    logic [31:0] r;
    r = $urandom;
    return {{(`XLEN - `MEM_AW - 2){1'b0}}, r[`MEM_AW-1:0], 2'b00};
  endfunction

  task automatic load_word(input logic [`XLEN-1:0] addr, input logic [`ILEN-1:0] data);
    @(posedge clk);
    load_en_i   <= 1'b1;
    load_addr_i <= addr;
    load_data_i <= data;
    image[addr[`MEM_AW+1:2]] = data;   // image wraps at 4 KiB like the memory
  endtask

  task automatic wait_checked(input int unsigned n);
    int unsigned goal;
    goal = n_checked + n;
    while (n_checked < goal) @(posedge clk);
  endtask

  // reference model, one compare per cycle on the falling edge
  always @(negedge clk) begin : fetch_monitor
    logic [`ILEN-1:0] exp_inst;
    if (rst_n) begin
      if (block_q) begin
        assert (!inst_valid_o)
          else stop_on_error("instruction presented in the cycle after a stall or redirect");
      end
      if (inst_valid_o) begin
        exp_inst = image[exp_pc[`MEM_AW+1:2]];
        assert (inst_pc_o == exp_pc) else flag_mismatch("inst_pc_o", exp_pc, inst_pc_o);
        assert (inst_o == exp_inst) else flag_mismatch("inst_o", exp_inst, inst_o);
        if (exp_inst[6:0] == `OPC_JAL) n_jal++;
        last_pc = exp_pc;
        exp_pc  = next_pc(exp_pc, exp_inst);
        n_checked++;
      end else begin
        assert (inst_o == `NOP_INST) else flag_mismatch("inst_o", `NOP_INST, inst_o);
      end
      if (redirect_i) exp_pc = redirect_pc_i; // sampled at the next rising edge
      block_q = stall_i || redirect_i;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, fetch stopped making progress",
             TIMEOUT_CYC);
    abort_run();
  end

  initial begin : stimulus
    logic [`XLEN-1:0] base;
    int               hold;
    logic             stall_lvl;
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(37));
    rst_n         = 1'b0;
    stall_i       = 1'b1;              // no fetch until the image is loaded
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    flush_i       = 1'b0;
    load_en_i     = 1'b0;
    load_addr_i   = '0;
    load_data_i   = '0;
    exp_pc        = `RESET_PC;
    last_pc       = `RESET_PC;
    block_q       = 1'b1;
    n_checked     = 0;
    n_jal         = 0;
    n_redirect    = 0;
    hold          = 0;
    stall_lvl     = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) image[i] = make_word();

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // program load through the plain port
    for (int i = 0; i < `MEM_WORDS; i++) load_word(32'(i) << 2, image[i]);
    @(posedge clk);
    load_en_i <= 1'b0;
    @(posedge clk);
    stall_i <= 1'b0;

    // straight fetch from reset over cold misses and hits
    wait_checked(N_STRAIGHT);

    // random stall levels and redirect pulses
    while (n_checked < N_STRAIGHT + N_RANDOM) begin
      @(posedge clk);
      if (hold == 0) begin
        stall_lvl = ($urandom_range(0, 3) == 0);
        hold      = $urandom_range(1, 6);
      end
      hold--;
      stall_i <= stall_lvl;
      if ($urandom_range(0, 31) == 0) begin
        redirect_i    <= 1'b1;
        redirect_pc_i <= rand_target();
        n_redirect++;
      end else begin
        redirect_i <= 1'b0;
      end
    end
    @(posedge clk);
    stall_i    <= 1'b1;
    redirect_i <= 1'b0;

    // last_pc holds the final presented instruction from this edge on
    @(posedge clk);
    base = {last_pc[`XLEN-1:`OFF_W+2], {(`OFF_W + 2){1'b0}}};
    // overwrite the last hit line and its neighbours
    for (int i = 0; i < 4 * `LINE_WORDS; i++) load_word(base + (32'(i) << 2), make_word());
    @(posedge clk);
    load_en_i <= 1'b0;
    flush_i   <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    repeat (4) @(posedge clk);
    redirect_i    <= 1'b1;             // back into the reloaded line
    redirect_pc_i <= base;
    n_redirect++;
    @(posedge clk);
    redirect_i <= 1'b0;
    stall_i    <= 1'b0;
    wait_checked(N_RELOAD);

    assert (n_jal > 0) else stop_on_error("no jal instruction reached the fetch stream");
    assert (n_redirect > 1) else stop_on_error("too few redirects were driven");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/if_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module if_stage (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              stall_i,
  input  wire              redirect_i,
  input  wire  [`XLEN-1:0] redirect_pc_i,
  input  wire              flush_i,
  input  wire              load_en_i,
  input  wire  [`XLEN-1:0] load_addr_i,
  input  wire  [`ILEN-1:0] load_data_i,
  output logic             inst_valid_o,
  output logic [`ILEN-1:0] inst_o,
  output logic [`XLEN-1:0] inst_pc_o
);
  import fetch_pkg::*;

  axi_rd_if       axi_bus ();         // master to memory
  cache_refill_if refill_bus ();      // cache to master

  // fetch lookup path
  logic             fetch_valid;
  logic [`XLEN-1:0] fetch_pc;
  logic             hit;
  inst_word_u       hit_data;

  pc_predict pc_predict_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o)
  );

  i_cache i_cache_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .lookup_valid_i (fetch_valid),
    .lookup_pc_i    (fetch_pc),
    .hit_o          (hit),
    .hit_data_o     (hit_data),
    .refill         (refill_bus.cache)
  );

  axi_rd_master axi_rd_master_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .refill (refill_bus.engine),
    .axi    (axi_bus.master)
  );

  inst_mem_slave inst_mem_slave_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .axi         (axi_bus.slave),
    .load_en_i   (load_en_i),         // program loader
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

`default_nettype wire

/* hdl/inst_mem_slave.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module inst_mem_slave (
  input  wire             clk,
  input  wire             rst_n,
  axi_rd_if.slave         axi,
  input  wire             load_en_i,
  input  wire [`XLEN-1:0] load_addr_i,
  input  wire [`ILEN-1:0] load_data_i
);

  localparam logic [1:0] ST_IDLE = 2'd0; // ready for an address
  localparam logic [1:0] ST_WAIT = 2'd1; // access latency
  localparam logic [1:0] ST_SEND = 2'd2; // streaming beats

  logic [`ILEN-1:0]  mem_q [`MEM_WORDS];
  logic [1:0]        state_q;
  logic [3:0]        dly_q;
  logic [7:0]        beat_q;
  logic [7:0]        len_q;
  logic [`MEM_AW-1:0] rd_addr_q;      // word address, wraps at 4 KiB
  logic              ar_hs;
  logic              r_hs;

  assign axi.ar_ready = (state_q == ST_IDLE);
  assign ar_hs        = axi.ar_valid && axi.ar_ready;
  assign axi.r_valid  = (state_q == ST_SEND);
  assign axi.r_data   = mem_q[rd_addr_q];
  assign axi.r_last   = (beat_q == len_q);
  assign r_hs         = axi.r_valid && axi.r_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      dly_q   <= '0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (ar_hs) begin
            state_q <= ST_WAIT;
            dly_q   <= 4'd1;          // first wait cycle
            beat_q  <= '0;
          end
        end
        ST_WAIT: begin
          if (dly_q >= 4'(`MEM_DELAY - 1)) begin
            state_q <= ST_SEND;
          end else begin
            dly_q <= dly_q + 1'b1;
          end
        end
        ST_SEND: begin
          if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (axi.r_last) state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // burst address and length
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr_q <= axi.ar_addr[`MEM_AW+1:2];
      len_q     <= axi.ar_len;
    end else if (r_hs) begin
      rd_addr_q <= rd_addr_q + 1'b1; // incr burst
    end
  end

  // loader port, independent of the axi side
  always_ff @(posedge clk) begin
    if (load_en_i) begin
      mem_q[load_addr_i[`MEM_AW+1:2]] <= load_data_i;
    end
  end

  // every burst starts a fixed delay after its address handshake
  a_r_after_ar: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(axi.r_valid) |-> $past(ar_hs, `MEM_DELAY)
  );

endmodule

`default_nettype wire

/* hdl/axi_rd_master.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module axi_rd_master (
  input  wire            clk,
  input  wire            rst_n,
  cache_refill_if.engine refill,
  axi_rd_if.master       axi
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1; // ar_valid up
  localparam logic [1:0] ST_DATA = 2'd2; // collecting beats

  logic [1:0]       state_q;
  logic [`XLEN-1:0] addr_q;           // line address held for the ar channel
  logic             r_hs;

  assign axi.ar_valid = (state_q == ST_ADDR);
  assign axi.ar_addr  = addr_q;
  assign axi.ar_len   = 8'(`LINE_WORDS - 1); // whole line per burst
  assign axi.r_ready  = (state_q == ST_DATA); // never back-pressures a refill

  assign r_hs = axi.r_valid && axi.r_ready;

  // beats go straight through to the cache
  assign refill.beat_valid = r_hs;
  assign refill.beat_data  = axi.r_data;
  assign refill.done       = r_hs && axi.r_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (refill.req) state_q <= ST_ADDR;
        ST_ADDR: if (axi.ar_ready) state_q <= ST_DATA;
        ST_DATA: if (refill.done) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (refill.req && (state_q == ST_IDLE)) begin
      addr_q <= refill.req_addr;
    end
  end

  // address may not move before the slave takes it
  a_ar_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    axi.ar_valid && !axi.ar_ready |=> $stable(axi.ar_addr)
  );

endmodule

`default_nettype wire

/* hdl/i_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module i_cache (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   flush_i,
  input  wire                   lookup_valid_i,
  input  wire  [`XLEN-1:0]      lookup_pc_i,
  output logic                  hit_o,
  output fetch_pkg::inst_word_u hit_data_o,
  cache_refill_if.cache         refill
);

  // pc split
  logic [`OFF_W-1:0]       off;
  logic [`IDX_W-1:0]       idx;
  logic [`TAG_W-1:0]       tag;

  // line storage
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`TAG_W-1:0]       tag_q  [`CACHE_LINES];
  logic [`ILEN-1:0]        data_q [`CACHE_LINES][`LINE_WORDS];

  // refill tracking
  logic                    refilling_q;
  logic                    flush_pend_q; // flush held back by a refill
  logic                    miss;
  logic                    flush_now;
  logic [`IDX_W-1:0]       fill_idx_q;
  logic [`TAG_W-1:0]       fill_tag_q;
  logic [`OFF_W-1:0]       fill_cnt_q;  // next beat slot
  logic                    req_q;
  logic [`XLEN-1:0]        req_addr_q;

  assign off = lookup_pc_i[`OFF_W+1:2];
  assign idx = lookup_pc_i[`IDX_W+`OFF_W+1:`OFF_W+2];
  assign tag = lookup_pc_i[`XLEN-1:`XLEN-`TAG_W];

  assign hit_o          = lookup_valid_i && valid_q[idx] && (tag_q[idx] == tag);
  assign hit_data_o.raw = data_q[idx][off];

  // only one refill in flight, later misses wait for it
  assign miss      = lookup_valid_i && !hit_o && !refilling_q;
  assign flush_now = (flush_i || flush_pend_q) && !refilling_q;

  assign refill.req      = req_q;
  assign refill.req_addr = req_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= '0;             // cold cache
      refilling_q  <= 1'b0;
      flush_pend_q <= 1'b0;
      req_q        <= 1'b0;
      fill_cnt_q   <= '0;
    end else begin
      req_q <= miss;                  // single pulse, refilling_q blocks repeats
      if (flush_now) begin
        valid_q <= '0;
      end
      if (miss) begin
        refilling_q  <= 1'b1;
        valid_q[idx] <= 1'b0;         // line gets overwritten beat by beat
        fill_cnt_q   <= '0;
      end
      if (refill.beat_valid) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
      end
      if (refill.done) begin
        refilling_q         <= 1'b0;
        valid_q[fill_idx_q] <= 1'b1;
      end
      if (flush_now) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i) begin
        flush_pend_q <= 1'b1;         // apply once the refill is done
      end
    end
  end

  // line data and tags
  always_ff @(posedge clk) begin
    if (miss) begin
      fill_idx_q <= idx;
      fill_tag_q <= tag;
      req_addr_q <= {lookup_pc_i[`XLEN-1:`OFF_W+2], {(`OFF_W+2){1'b0}}};
    end
    if (refill.beat_valid) begin
      data_q[fill_idx_q][fill_cnt_q] <= refill.beat_data;
    end
    if (refill.done) begin
      tag_q[fill_idx_q] <= fill_tag_q;
    end
  end

  // a new request never overlaps a running refill
  a_req_not_refilling: assert property (
    @(posedge clk) disable iff (!rst_n) refill.req |-> !$past(refilling_q)
  );

  // the engine finishes only what was asked for
  a_done_in_refill: assert property (
    @(posedge clk) disable iff (!rst_n) refill.done |-> refilling_q && !refill.req
  );

endmodule

`default_nettype wire

/* hdl/pc_predict.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module pc_predict (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   stall_i,
  input  wire                   redirect_i,
  input  wire  [`XLEN-1:0]      redirect_pc_i,
  output logic                  fetch_valid_o,
  output logic [`XLEN-1:0]      fetch_pc_o,
  input  wire                   hit_i,
  input  wire fetch_pkg::inst_word_u hit_data_i,
  output logic                  inst_valid_o,
  output logic [`ILEN-1:0]      inst_o,
  output logic [`XLEN-1:0]      inst_pc_o
);
  import fetch_pkg::*;

  logic [`XLEN-1:0] pc_q;             // fetch pc
  logic [`XLEN-1:0] pc_nxt;           // predicted successor
  logic [`XLEN-1:0] j_imm;
  logic             take;             // lookup hit, instruction accepted
  logic             inst_valid_q;
  inst_word_u       inst_q;
  logic [`XLEN-1:0] inst_pc_q;

  assign fetch_valid_o = !stall_i && !redirect_i; // no lookup on stall or redirect
  assign fetch_pc_o    = pc_q;
  assign take          = fetch_valid_o && hit_i;

  // j-type immediate, bit 0 always zero
  assign j_imm = {{(`XLEN - 20){hit_data_i.j.imm20}},
                  hit_data_i.j.imm19_12,
                  hit_data_i.j.imm11,
                  hit_data_i.j.imm10_1,
                  1'b0};

  // jal is taken statically, everything else falls through
  always_comb begin
    if (hit_data_i.j.opcode == `OPC_JAL) begin
      pc_nxt = pc_q + j_imm;
    end else begin
      pc_nxt = pc_q + 'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q         <= `RESET_PC;
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= take;           // low after redirect or stall
      if (redirect_i) begin
        pc_q <= redirect_pc_i;        // overrides prediction
      end else if (take) begin
        pc_q <= pc_nxt;
      end
    end
  end

  // presented instruction and its pc
  always_ff @(posedge clk) begin
    if (take) begin
      inst_q    <= hit_data_i;
      inst_pc_q <= pc_q;
    end
  end

  assign inst_valid_o = inst_valid_q;
  assign inst_o       = inst_valid_q ? inst_q.raw : `NOP_INST; // bubble
  assign inst_pc_o    = inst_pc_q;

  // the redirect cycle never produces an instruction
  a_no_inst_after_redirect: assert property (
    @(posedge clk) disable iff (!rst_n) redirect_i |=> !inst_valid_o
  );

endmodule

`default_nettype wire

/* hdl/cache_refill_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

// line refill between i_cache and the axi read engine
interface cache_refill_if;

  logic             req;              // one-cycle pulse, one refill at a time
  logic [`XLEN-1:0] req_addr;         // line aligned
  logic             beat_valid;
  logic [`ILEN-1:0] beat_data;
  logic             done;             // with the last beat

  modport cache (
    output req, req_addr,
    input  beat_valid, beat_data, done
  );

  modport engine (
    input  req, req_addr,
    output beat_valid, beat_data, done
  );

endinterface

`default_nettype wire

/* hdl/axi_rd_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

// axi read address + read data channels, no ids, no resp
interface axi_rd_if;

  // ar channel
  logic             ar_valid;
  logic             ar_ready;
  logic [`XLEN-1:0] ar_addr;
  logic [7:0]       ar_len;           // beats minus one, incr burst

  // r channel
  logic             r_valid;
  logic             r_ready;
  logic [`ILEN-1:0] r_data;
  logic             r_last;           // final beat of the burst

  modport master (
    output ar_valid, ar_addr, ar_len, r_ready,
    input  ar_ready, r_valid, r_data, r_last
  );

  modport slave (
    input  ar_valid, ar_addr, ar_len, r_ready,
    output ar_ready, r_valid, r_data, r_last
  );

endinterface

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

  // one instruction word, seen raw or as j-type fields
  typedef union packed {
    logic [`ILEN-1:0] raw;            // as stored in the cache
    struct packed {
      logic       imm20;              // inst[31], sign bit
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_word_u;

endpackage

`default_nettype wire

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// datapath widths
`define XLEN        32
`define ILEN        32

// cache geometry
`define LINE_WORDS  4                 // words per line, also beats per burst
`define CACHE_LINES 16
`define OFF_W       2                 // log2 of LINE_WORDS
`define IDX_W       4                 // log2 of CACHE_LINES
`define TAG_W       (`XLEN - `IDX_W - `OFF_W - 2)

// backing memory
`define MEM_WORDS   1024              // 4 KiB, addresses wrap
`define MEM_AW      10                // log2 of MEM_WORDS
`define MEM_DELAY   2                 // cycles from accepted address to first beat

// fetch constants
`define RESET_PC    32'h0000_0000
`define NOP_INST    32'h0000_0013     // addi x0 x0 0
`define OPC_JAL     7'b110_1111

`endif
